// File: common/periph_consts.svh
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

//================================================
// Widths
//================================================
`define IRQ_NUM			8		// Interrupt lines, also source vector width
`define IRQ_ID_W		3		// Interrupt number
`define IRQ_ASYNC_NUM	4		// bastim lines
`define APB_DATA_W		32
`define APB_ADDR_W		12		// Offset inside the peripheral window
`define IRQ_SYNC_STAGES	2		// Flops per async line

//================================================
// Register word offsets
//================================================
`define REG_ENABLE		12'h000	// RW
`define REG_PENDING		12'h004	// Read, write 1 to clear
`define REG_RAW			12'h008	// RO
`define REG_SWSET		12'h00C	// WO, write 1 to set

// Source vector bit positions
`define IRQ_BIT_UART0	0
`define IRQ_BIT_UART1	1
`define IRQ_BIT_GPIOA	2
`define IRQ_BIT_RSVD	3		// Tied low
`define IRQ_BIT_BASTIM	4		// Lowest of the four timer lines

`endif

// File: common/apb_pkg.sv
`include "periph_consts.svh"

package apb_pkg;

	//================================================
	// APB data path
	//================================================
	typedef logic [`APB_DATA_W-1:0] apb_data_t;	// One bus word
	typedef logic [`APB_ADDR_W-1:0] apb_addr_t;	// Offset in window

	// Decoded register select
	typedef enum logic [2:0] {
		SEL_NONE,		// Unmapped offset
		SEL_ENABLE,
		SEL_PENDING,
		SEL_RAW,
		SEL_SWSET
	} reg_sel_e;

endpackage

// File: common/irq_pkg.sv
`include "periph_consts.svh"

package irq_pkg;

	// Named sources, MSB first so positions match the consts header
	typedef struct packed {
		logic [`IRQ_NUM-1:`IRQ_BIT_BASTIM]	bastim;	// Timer lines 4..7
		logic								rsvd;	// No source behind it
		logic								gpioa;
		logic								uart1;
		logic								uart0;
	} irq_src_t;

	// One byte, two decodings
	typedef union packed {
		logic [`IRQ_NUM-1:0]	raw;	// Masking and priority
		irq_src_t				src;	// Per-source access
	} irq_vec_u;

	typedef logic [`IRQ_ID_W-1:0] irq_id_t;	// Interrupt number

	// Timer lines before the synchronizer
	typedef logic [`IRQ_ASYNC_NUM-1:0] async_src_t;

endpackage

// File: irq/irq_async_sync.sv
`timescale 1ns/1ps

`include "periph_consts.svh"

module irq_async_sync
#(
	parameter int WIDTH		= `IRQ_ASYNC_NUM,	// Lines to bring over
	parameter int STAGES	= `IRQ_SYNC_STAGES	// Chain depth
)
(
	input						sys_root_clk,
	input						arst_n_i,

	input	irq_pkg::async_src_t	async_i,	// Timer lines, any phase
	output	irq_pkg::async_src_t	sync_o		// Safe in sys_root_clk domain
);

//================================================
// Shift chain
//================================================

logic [STAGES-1:0][WIDTH-1:0]	chain_q;	// Stage 0 takes the raw line

always_ff @(posedge sys_root_clk or negedge arst_n_i) begin
	if (!arst_n_i) begin
		chain_q <= '0;	// All lines idle low
	end else begin
		chain_q[0] <= async_i;	// First stage may go metastable
		for (int i = 1; i < STAGES; i++) begin
			chain_q[i] <= chain_q[i-1];
		end
	end
end

// Last stage only
assign sync_o = chain_q[STAGES-1];

endmodule

// File: irq/irq_pending_unit.sv
`timescale 1ns/1ps

`include "periph_consts.svh"

module irq_pending_unit
(
	input							sys_root_clk,
	input							arst_n_i,

	// Synchronous sources
	input							uart0_irq_i,	// No.0
	input							uart1_irq_i,	// No.1
	input							gpioa_irq_i,	// No.2
	input	irq_pkg::async_src_t	bastim_sync_i,	// No.4~7, already synced

	// From the register file
	input	irq_pkg::irq_vec_u		enable_i,
	input							clr_stb_i,		// PENDING write
	input							set_stb_i,		// SWSET write
	input	irq_pkg::irq_vec_u		wr_mask_i,		// Write data of either strobe

	// Back to the register file
	output	irq_pkg::irq_vec_u		raw_o,
	output	irq_pkg::irq_vec_u		pending_o,

	// Combined request
	output	logic					irq_o,
	output	irq_pkg::irq_id_t		irq_id_o
);

//================================================
// Raw vector assembly
//================================================

irq_pkg::irq_vec_u		raw_vec;
irq_pkg::irq_vec_u		sw_set;		// Software set bits
irq_pkg::irq_vec_u		sw_clr;		// Write 1 to clear bits
irq_pkg::irq_vec_u		pend_q;
logic [`IRQ_NUM-1:0]	active_vec;	// Pending and enabled

always_comb begin
	raw_vec				= '0;
	raw_vec.src.uart0	= uart0_irq_i;
	raw_vec.src.uart1	= uart1_irq_i;
	raw_vec.src.gpioa	= gpioa_irq_i;
	raw_vec.src.rsvd	= 1'b0;				// Nothing wired here
	raw_vec.src.bastim	= bastim_sync_i;
end

// Software may not raise the reserved line either
always_comb begin
	sw_set			= set_stb_i ? wr_mask_i : '0;
	sw_set.src.rsvd	= 1'b0;
	sw_clr			= clr_stb_i ? wr_mask_i : '0;
end

//================================================
// Pending register
//================================================

always_ff @(posedge sys_root_clk or negedge arst_n_i) begin
	if (!arst_n_i) begin
		pend_q <= '0;
	end else begin
		// Set beats clear in the same cycle
		pend_q.raw <= (pend_q.raw & ~sw_clr.raw) | raw_vec.raw | sw_set.raw;
	end
end

assign raw_o		= raw_vec;
assign pending_o	= pend_q;

// Masking and lowest index wins
assign active_vec	= pend_q.raw & enable_i.raw;
assign irq_o		= |active_vec;

always_comb begin
	irq_id_o = '0;	// Stays zero with nothing active
	for (int i = `IRQ_NUM-1; i >= 0; i--) begin
		if (active_vec[i]) begin
			irq_id_o = irq_pkg::irq_id_t'(i);	// Lower index overrides
		end
	end
end

endmodule

// File: hdl/apb_irq_regs.sv
`timescale 1ns/1ps

`include "periph_consts.svh"

module apb_irq_regs
(
	input							sys_root_clk,
	input							arst_n_i,

	// APB slave, zero wait states
	input							psel_i,
	input							penable_i,
	input							pwrite_i,
	input	apb_pkg::apb_addr_t		paddr_i,
	input	apb_pkg::apb_data_t		pwdata_i,
	output	apb_pkg::apb_data_t		prdata_o,
	output	logic					pready_o,
	output	logic					pslverr_o,

	// Status for reads
	input	irq_pkg::irq_vec_u		pending_i,
	input	irq_pkg::irq_vec_u		raw_i,

	// Control to the pending unit
	output	irq_pkg::irq_vec_u		enable_o,
	output	logic					clr_stb_o,	// One cycle, PENDING write
	output	logic					set_stb_o,	// One cycle, SWSET write
	output	irq_pkg::irq_vec_u		wr_mask_o
);

localparam int PAD_W = `APB_DATA_W - `IRQ_NUM;	// Zero fill on reads

apb_pkg::reg_sel_e		reg_sel;
irq_pkg::irq_vec_u		enable_q;
logic					acc_phase;	// psel and penable both high
logic					wr_acc;
logic					rd_acc;
logic					bad_acc;	// Unmapped or wrong direction
logic [`IRQ_NUM-1:0]	rd_vec;

//================================================
// Address decode
//================================================

always_comb begin
	case (paddr_i)
		`REG_ENABLE:	reg_sel = apb_pkg::SEL_ENABLE;
		`REG_PENDING:	reg_sel = apb_pkg::SEL_PENDING;
		`REG_RAW:		reg_sel = apb_pkg::SEL_RAW;
		`REG_SWSET:		reg_sel = apb_pkg::SEL_SWSET;
		default:		reg_sel = apb_pkg::SEL_NONE;
	endcase
end

assign acc_phase	= psel_i & penable_i;
assign wr_acc		= acc_phase & pwrite_i;
assign rd_acc		= acc_phase & ~pwrite_i;

// RAW is read only and SWSET write only
assign bad_acc = (reg_sel == apb_pkg::SEL_NONE)
			| (pwrite_i & (reg_sel == apb_pkg::SEL_RAW))
			| (~pwrite_i & (reg_sel == apb_pkg::SEL_SWSET));

assign pready_o		= acc_phase;			// Never stalls
assign pslverr_o	= acc_phase & bad_acc;

//================================================
// Enable register
//================================================

always_ff @(posedge sys_root_clk or negedge arst_n_i) begin
	if (!arst_n_i) begin
		enable_q <= '0;	// Everything masked
	end else if (wr_acc && (reg_sel == apb_pkg::SEL_ENABLE)) begin
		enable_q.raw <= pwdata_i[`IRQ_NUM-1:0];	// Upper bits ignored
	end
end

assign enable_o = enable_q;

// Strobes land at the edge closing the access phase
assign clr_stb_o		= wr_acc & (reg_sel == apb_pkg::SEL_PENDING);
assign set_stb_o		= wr_acc & (reg_sel == apb_pkg::SEL_SWSET);
assign wr_mask_o.raw	= pwdata_i[`IRQ_NUM-1:0];

//================================================
// Read mux
//================================================

always_comb begin
	case (reg_sel)
		apb_pkg::SEL_ENABLE:	rd_vec = enable_q.raw;
		apb_pkg::SEL_PENDING:	rd_vec = pending_i.raw;	// Unmasked state
		apb_pkg::SEL_RAW:		rd_vec = raw_i.raw;
		default:				rd_vec = '0;	// SWSET and holes read zero
	endcase
end

// Driven only in a read access phase
assign prdata_o = rd_acc ? {{PAD_W{1'b0}}, rd_vec} : '0;

endmodule

// File: hdl/periph_irq_domain.sv
`timescale 1ns/1ps

`include "periph_consts.svh"

module periph_irq_domain
(
	input							sys_root_clk,
	input							arst_n_i,

	// APB slave port
	input							psel_i,
	input							penable_i,
	input							pwrite_i,
	input	apb_pkg::apb_addr_t		paddr_i,
	input	apb_pkg::apb_data_t		pwdata_i,
	output	apb_pkg::apb_data_t		prdata_o,
	output	logic					pready_o,
	output	logic					pslverr_o,

	// Interrupt sources
	input							uart0_irq_i,	// No.0, sync
	input							uart1_irq_i,	// No.1, sync
	input							gpioa_irq_i,	// No.2, sync
	input	irq_pkg::async_src_t	bastim_irq_i,	// No.4~7, async

	// Combined request
	output	logic					irq_o,
	output	irq_pkg::irq_id_t		irq_id_o
);

irq_pkg::async_src_t	bastim_sync;
irq_pkg::irq_vec_u		enable;
irq_pkg::irq_vec_u		wr_mask;
irq_pkg::irq_vec_u		pending;
irq_pkg::irq_vec_u		raw;
logic					clr_stb;
logic					set_stb;

//================================================
// Async timer lines
//================================================

irq_async_sync
#(
	.WIDTH			(`IRQ_ASYNC_NUM),
	.STAGES			(`IRQ_SYNC_STAGES)
)
u_irq_async_sync
(
	.sys_root_clk	(sys_root_clk),
	.arst_n_i		(arst_n_i),
	.async_i		(bastim_irq_i),
	.sync_o			(bastim_sync)
);

//================================================
// Register file
//================================================

apb_irq_regs u_apb_irq_regs
(
	.sys_root_clk	(sys_root_clk),
	.arst_n_i		(arst_n_i),
	.psel_i			(psel_i),
	.penable_i		(penable_i),
	.pwrite_i		(pwrite_i),
	.paddr_i		(paddr_i),
	.pwdata_i		(pwdata_i),
	.prdata_o		(prdata_o),
	.pready_o		(pready_o),
	.pslverr_o		(pslverr_o),
	.pending_i		(pending),		// Fed back for reads
	.raw_i			(raw),
	.enable_o		(enable),
	.clr_stb_o		(clr_stb),
	.set_stb_o		(set_stb),
	.wr_mask_o		(wr_mask)
);

// Pending state and priority
irq_pending_unit u_irq_pending_unit
(
	.sys_root_clk	(sys_root_clk),
	.arst_n_i		(arst_n_i),
	.uart0_irq_i	(uart0_irq_i),
	.uart1_irq_i	(uart1_irq_i),
	.gpioa_irq_i	(gpioa_irq_i),
	.bastim_sync_i	(bastim_sync),
	.enable_i		(enable),
	.clr_stb_i		(clr_stb),
	.set_stb_i		(set_stb),
	.wr_mask_i		(wr_mask),
	.raw_o			(raw),
	.pending_o		(pending),
	.irq_o			(irq_o),
	.irq_id_o		(irq_id_o)
);

endmodule

// File: sim/periph_irq_asserts.sv
`timescale 1ns/1ps

module periph_irq_asserts
(
	input						sys_root_clk,
	input						arst_n_i,
	input	irq_pkg::irq_vec_u	raw_i,
	input	irq_pkg::irq_vec_u	pending_i,
	input	irq_pkg::irq_vec_u	enable_i,
	input						irq_i,
	input	irq_pkg::irq_id_t	irq_id_i
);

//================================================
// Pending unit rules
//================================================

// Request is the OR of the masked pending bits
irq_or_a: assert property (@(posedge sys_root_clk) disable iff (!arst_n_i)
	irq_i == |(pending_i.raw & enable_i.raw))
	else $error("irq_o differs from the OR of pending and enable");

// Reported ID points at a live source
id_live_a: assert property (@(posedge sys_root_clk) disable iff (!arst_n_i)
	irq_i |-> (pending_i.raw[irq_id_i] && enable_i.raw[irq_id_i]))
	else $error("irq_id_o names a bit that is not pending and enabled");

rsvd_low_a: assert property (@(posedge sys_root_clk) disable iff (!arst_n_i)
	!raw_i.src.rsvd)	// Nothing drives bit 3
	else $error("reserved raw bit went high");

endmodule

bind irq_pending_unit periph_irq_asserts u_irq_asserts
(
	.sys_root_clk	(sys_root_clk),
	.arst_n_i		(arst_n_i),
	.raw_i			(raw_o),
	.pending_i		(pending_o),
	.enable_i		(enable_i),
	.irq_i			(irq_o),
	.irq_id_i		(irq_id_o)
);

// File: sim/tb_periph_irq_domain.sv
`timescale 1ns/1ps

`include "periph_consts.svh"

module tb_periph_irq_domain;

localparam int MAX_CYCLES = 2000;	// Whole run needs a few hundred cycles

logic					clk = 1'b0;
logic					arst_n;
logic					psel, penable, pwrite;
apb_pkg::apb_addr_t		paddr;
apb_pkg::apb_data_t		pwdata, prdata;
logic					pready, pslverr;
logic					uart0_irq, uart1_irq, gpioa_irq;
irq_pkg::async_src_t	bastim_irq;
logic					irq;
irq_pkg::irq_id_t		irq_id;
logic [31:0]			lfsr = 32'hf6717ccb;
int						cycles = 0;
int						vec_errs = 0, data_errs = 0, id_errs = 0, flag_errs = 0;

periph_irq_domain DUT (
	.sys_root_clk(clk), .arst_n_i(arst_n), .psel_i(psel), .penable_i(penable),
	.pwrite_i(pwrite), .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata),
	.pready_o(pready), .pslverr_o(pslverr), .uart0_irq_i(uart0_irq),
	.uart1_irq_i(uart1_irq), .gpioa_irq_i(gpioa_irq), .bastim_irq_i(bastim_irq),
	.irq_o(irq), .irq_id_o(irq_id)
);

always #10 clk = ~clk;	// 20 ns period

always @(posedge clk) begin
	cycles <= cycles + 1;
	if (cycles >= MAX_CYCLES) begin
		$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end
end

//================================================
// Random bits and reference model helpers
//================================================
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// Taps 32,22,2,1
endfunction

task automatic rand_bits(input int n, output logic [31:0] v);
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr = lfsr_next(lfsr);
		v = {v[30:0], lfsr[0]};	// One step per bit
	end
endtask

// Lowest set index wins
function automatic irq_pkg::irq_id_t lowest_index(input apb_pkg::apb_data_t v);
	logic found;
	found = 1'b0;
	lowest_index = '0;
	for (int i = 0; i < `IRQ_NUM; i++) begin
		if (v[i] && !found) begin
			lowest_index = irq_pkg::irq_id_t'(i);
			found = 1'b1;
		end
	end
endfunction

//================================================
// Compare tasks
//================================================
task automatic check_vec(input string name, input irq_pkg::irq_vec_u exp, act);
	if (exp !== act) begin
		$display("ERROR %s: expected %02h, actual %02h", name, exp.raw, act.raw);
		vec_errs++;
	end
endtask

task automatic check_data(input string name, input apb_pkg::apb_data_t exp, act);
	if (exp !== act) begin
		$display("ERROR %s: expected %08h, actual %08h", name, exp, act);
		data_errs++;
	end
endtask

task automatic check_id(input string name, input irq_pkg::irq_id_t exp, act);
	if (exp !== act) begin
		$display("ERROR %s: expected %0d, actual %0d", name, exp, act);
		id_errs++;
	end
endtask

task automatic check_flag(input string name, input logic exp, act);
	if (exp !== act) begin
		$display("ERROR %s: expected %0b, actual %0b", name, exp, act);
		flag_errs++;
	end
endtask

// Sampled clear of any edge
task automatic check_irq(input string name, input logic exp_irq, input irq_pkg::irq_id_t exp_id);
	#2;
	check_flag({name, " irq_o"}, exp_irq, irq);
	check_id({name, " irq_id_o"}, exp_id, irq_id);
endtask

//================================================
// APB master
//================================================
task automatic apb_access(input logic wr, input apb_pkg::apb_addr_t addr,
		input apb_pkg::apb_data_t wdata, output apb_pkg::apb_data_t rdata,
		output logic err, output logic rdy);
	@(negedge clk);	// Setup phase
	psel = 1'b1;
	penable = 1'b0;
	pwrite = wr;
	paddr = addr;
	pwdata = wdata;
	@(negedge clk);
	penable = 1'b1;
	#5;
	rdy = pready;	// Zero wait states, high in the first access cycle
	while (!pready) begin	// Slave handshake, timeout via cycle counter
		@(negedge clk);
		#5;
	end
	rdata = prdata;
	err = pslverr;
	@(negedge clk);	// Access ended at the rising edge
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
endtask

task automatic apb_write(input string name, input apb_pkg::apb_addr_t addr,
		input apb_pkg::apb_data_t data, input logic exp_err);
	apb_pkg::apb_data_t	rd;
	logic				err;
	logic				rdy;
	apb_access(1'b1, addr, data, rd, err, rdy);
	check_flag({name, " pready"}, 1'b1, rdy);
	check_flag({name, " pslverr"}, exp_err, err);
endtask

task automatic read_vec(input string name, input apb_pkg::apb_addr_t addr,
		input apb_pkg::apb_data_t exp, input logic exp_err);
	apb_pkg::apb_data_t	rd;
	logic				err;
	logic				rdy;
	irq_pkg::irq_vec_u	exp_v, act_v;
	apb_access(1'b0, addr, '0, rd, err, rdy);
	check_flag({name, " pready"}, 1'b1, rdy);
	check_flag({name, " pslverr"}, exp_err, err);
	exp_v.raw = exp[`IRQ_NUM-1:0];
	act_v.raw = rd[`IRQ_NUM-1:0];
	if (!exp_err) check_vec(name, exp_v, act_v);
	check_data({name, " upper bits"}, '0, rd >> `IRQ_NUM);	// Zero fill
endtask

//================================================
// Tests
//================================================
task automatic test_reset_values();
	read_vec("reset ENABLE", `REG_ENABLE, '0, 1'b0);
	read_vec("reset PENDING", `REG_PENDING, '0, 1'b0);
	read_vec("reset RAW", `REG_RAW, '0, 1'b0);
	check_irq("reset", 1'b0, '0);
	check_data("reset idle prdata", '0, prdata);	// Bus idle here
	check_flag("reset idle pslverr", 1'b0, pslverr);
endtask

task automatic test_register_access();
	logic [31:0] mask;
	rand_bits(`IRQ_NUM, mask);
	apb_write("enable write", `REG_ENABLE, mask, 1'b0);
	read_vec("enable readback", `REG_ENABLE, mask, 1'b0);
	apb_write("unmapped write", 12'h010, 32'hffff_ffff, 1'b1);
	apb_write("RAW write", `REG_RAW, 32'h0000_00ff, 1'b1);
	read_vec("SWSET read", `REG_SWSET, '0, 1'b1);
	apb_write("enable restore", `REG_ENABLE, '0, 1'b0);
endtask

task automatic test_sync_source();
	@(negedge clk) uart1_irq = 1'b1;	// One-cycle pulse
	@(negedge clk) uart1_irq = 1'b0;
	read_vec("uart1 pending", `REG_PENDING, 32'h02, 1'b0);
	repeat (3) @(posedge clk);
	read_vec("uart1 sticky", `REG_PENDING, 32'h02, 1'b0);
	check_irq("uart1 masked", 1'b0, '0);
	apb_write("uart1 enable", `REG_ENABLE, 32'h02, 1'b0);
	check_irq("uart1 enabled", 1'b1, 3'd1);
	apb_write("uart1 clear", `REG_PENDING, 32'h02, 1'b0);
	read_vec("uart1 cleared", `REG_PENDING, '0, 1'b0);
	check_irq("uart1 cleared", 1'b0, '0);
	apb_write("uart1 disable", `REG_ENABLE, '0, 1'b0);
endtask

task automatic test_async_source();
	logic [31:0]		rnd;
	int					k;
	apb_pkg::apb_data_t	bit_mask;
	rand_bits(2, rnd);
	k = int'(rnd[1:0]);
	bit_mask = apb_pkg::apb_data_t'(1) << (`IRQ_BIT_BASTIM + k);
	apb_write("bastim enable", `REG_ENABLE, bit_mask, 1'b0);
	@(negedge clk) bastim_irq[k] = 1'b1;
	repeat (2) @(posedge clk);
	check_irq("bastim two edges", 1'b0, '0);	// Still in the synchronizer
	@(posedge clk);
	check_irq("bastim three edges", 1'b1, irq_pkg::irq_id_t'(`IRQ_BIT_BASTIM + k));
	read_vec("bastim RAW", `REG_RAW, bit_mask, 1'b0);
	read_vec("bastim PENDING", `REG_PENDING, bit_mask, 1'b0);
	@(negedge clk) bastim_irq[k] = 1'b0;
	repeat (3) @(posedge clk);	// Drain the chain
	apb_write("bastim clear", `REG_PENDING, bit_mask, 1'b0);
	read_vec("bastim PENDING cleared", `REG_PENDING, '0, 1'b0);
	read_vec("bastim RAW low", `REG_RAW, '0, 1'b0);
	apb_write("bastim disable", `REG_ENABLE, '0, 1'b0);
endtask

task automatic test_priority();
	logic [31:0]		set_v, en_v;
	apb_pkg::apb_data_t	active;
	irq_pkg::irq_id_t	id;
	rand_bits(`IRQ_NUM, set_v);
	rand_bits(`IRQ_NUM, en_v);
	set_v[`IRQ_BIT_RSVD] = 1'b0;	// No source behind bit 3
	apb_write("prio swset", `REG_SWSET, set_v, 1'b0);
	apb_write("prio enable", `REG_ENABLE, en_v, 1'b0);
	read_vec("prio pending", `REG_PENDING, set_v, 1'b0);
	active = set_v & en_v;
	while (active != '0) begin
		id = lowest_index(active);
		check_irq("prio lowest", 1'b1, id);
		apb_write("prio clear", `REG_PENDING, apb_pkg::apb_data_t'(1) << id, 1'b0);
		active[id] = 1'b0;
	end
	check_irq("prio none left", 1'b0, '0);
	apb_write("prio clear all", `REG_PENDING, 32'h0000_00ff, 1'b0);
	apb_write("prio disable", `REG_ENABLE, '0, 1'b0);
endtask

initial begin
	arst_n = 1'b0;
	{psel, penable, pwrite} = '0;
	paddr = '0;
	pwdata = '0;
	{uart0_irq, uart1_irq, gpioa_irq} = '0;
	bastim_irq = '0;
	repeat (2) @(posedge clk);
	@(negedge clk) arst_n = 1'b1;
	test_reset_values();
	test_register_access();
	test_sync_source();
	test_async_source();
	test_priority();
	test_priority();	// Second random draw
	$display("Errors: vec %0d, data %0d, id %0d, flag %0d",
		vec_errs, data_errs, id_errs, flag_errs);
	if (vec_errs + data_errs + id_errs + flag_errs == 0) begin
		$display("=== PASS ===");
	end else begin
		$display("=== FAIL ===");
	end
	$finish;
end

endmodule

// File: sim.f
+incdir+common
common/apb_pkg.sv
common/irq_pkg.sv
irq/irq_async_sync.sv
irq/irq_pending_unit.sv
hdl/apb_irq_regs.sv
hdl/periph_irq_domain.sv
sim/periph_irq_asserts.sv
sim/tb_periph_irq_domain.sv

// File: Makefile
# Verilator build and run for the interrupt collector

VERILATOR ?= verilator
TOP       ?= tb_periph_irq_domain
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search output for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
